// ==== common/dma_rd_pkg.sv ====
package dma_rd_pkg;

    // ==============================
    // sizes
    // ==============================
    localparam int ADDR_W       = 32;
    localparam int BEAT_BYTES   = 16;   // one 128-bit beat
    localparam int BURST8_BEATS = 8;
    localparam int BURST8_LEN   = 7;    // axi len code, beats minus one

    // ==============================
    // vector types
    // ==============================
    typedef logic [ADDR_W-1:0] addr_t;       // byte address
    typedef logic [31:0]       word_cnt_t;   // request length in 32-bit words
    typedef logic [22:0]       burst_cnt_t;  // bursts per request
    typedef logic [3:0]        burst_len_t;  // axi len code
    typedef logic [3:0]        beat_ofs_t;   // byte offset inside a beat
    typedef logic [3:0]        outstd_t;     // outstanding limit

    // ==============================
    // burst state machine
    // ==============================
    typedef enum logic [2:0] {
        IDLE,
        LOAD,    // decode results just captured
        BURST8,  // full 8-beat bursts
        LAST,    // one short burst
        DRAIN    // wait for the data to come back
    } trans_state_e;

endpackage

// ==== hw/rd_req_decode.sv ====
`timescale 1ns/10ps

module rd_req_decode
    import dma_rd_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,

    input  logic       req_pop,
    input  addr_t      raddr_fifo_raddr_in,
    input  word_cnt_t  raddr_fifo_rd_num_word,

    output addr_t      start_addr,
    output burst_cnt_t num_burst8,
    output burst_len_t last_len,
    output burst_cnt_t total_bursts,
    output beat_ofs_t  strb_first_beat_num,
    output beat_ofs_t  strb_last_beat_num
);

    addr_t      word_addr;
    addr_t      aligned_addr;
    addr_t      end_addr;
    addr_t      span;
    addr_t      beat_raw;
    addr_t      beat_cnt;
    burst_cnt_t num_burst8_w;
    burst_len_t last_len_w;

    // ==============================
    // decode of the fifo word
    // ==============================
    assign word_addr    = {raddr_fifo_raddr_in[ADDR_W-1:2], 2'b00};
    assign aligned_addr = {word_addr[ADDR_W-1:4], 4'b0000};
    assign end_addr     = word_addr + (raddr_fifo_rd_num_word << 2);  // words to bytes

    // beats touched, rounded up
    assign span     = end_addr - aligned_addr;
    assign beat_raw = (span + addr_t'(BEAT_BYTES - 1)) / BEAT_BYTES;
    assign beat_cnt = (beat_raw == '0) ? addr_t'(1) : beat_raw;  // at least one beat

    assign num_burst8_w = burst_cnt_t'(beat_cnt / BURST8_BEATS);
    assign last_len_w   = burst_len_t'(beat_cnt % BURST8_BEATS);

    // ==============================
    // capture on pop
    // ==============================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            start_addr          <= '0;
            num_burst8          <= '0;
            last_len            <= '0;
            total_bursts        <= '0;
            strb_first_beat_num <= '0;
            strb_last_beat_num  <= '0;
        end else if (req_pop) begin
            start_addr          <= aligned_addr;
            num_burst8          <= num_burst8_w;
            last_len            <= last_len_w;
            total_bursts        <= num_burst8_w + burst_cnt_t'(last_len_w != '0);
            strb_first_beat_num <= word_addr[3:0];   // first valid byte in beat 0
            strb_last_beat_num  <= end_addr[3:0];    // end of data in the last beat
        end
    end

endmodule

// ==== hw/burst_seq.sv ====
`timescale 1ns/10ps

module burst_seq
    import dma_rd_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,

    input  logic       rd_cfg_ready,
    input  outstd_t    rd_cfg_outstd,
    input  logic       rd_cfg_outstd_en,
    input  logic       raddr_fifo_empty,

    input  burst_cnt_t num_burst8,
    input  burst_len_t last_len,
    input  burst_cnt_t total_bursts,
    input  addr_t      start_addr,

    input  logic       dma_raddr_burst_ok,
    input  burst_cnt_t bursts_returned,
    input  logic       data_done,

    output logic       req_pop,
    output addr_t      dma_trans_burst_addr,
    output burst_len_t dma_trans_burst_len,
    output logic       dma_trans_burst_avalid,
    output logic       read_all_done
);

    trans_state_e state_q;
    trans_state_e state_d;

    logic       run_q;
    burst_cnt_t issued_q;     // accepted bursts of this request
    burst_cnt_t in_flight;
    outstd_t    limit;
    logic       accept;
    logic       issuing;
    logic       more_to_issue;
    logic       window_open;

    assign accept  = dma_trans_burst_avalid && dma_raddr_burst_ok;
    assign issuing = (state_q == BURST8) || (state_q == LAST);

    assign req_pop       = (state_q == IDLE) && run_q && !raddr_fifo_empty;
    assign read_all_done = (state_q == DRAIN) && data_done;

    // set by cfg, dropped once the request is complete
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            run_q <= 1'b0;
        else if (rd_cfg_ready)
            run_q <= 1'b1;
        else if (read_all_done)
            run_q <= 1'b0;
    end

    // ==============================
    // state machine
    // ==============================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:   if (req_pop) state_d = LOAD;
            LOAD:   state_d = (num_burst8 != '0) ? BURST8 : LAST;
            BURST8: begin
                if (accept && issued_q == num_burst8 - 1'b1)
                    state_d = (last_len != '0) ? LAST : DRAIN;
            end
            LAST:   if (accept) state_d = DRAIN;
            DRAIN:  if (data_done) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            issued_q <= '0;
        else if (state_q == LOAD)
            issued_q <= '0;
        else if (accept)
            issued_q <= issued_q + 1'b1;
    end

    // ==============================
    // in-flight window
    // ==============================
    assign limit = (rd_cfg_outstd_en && rd_cfg_outstd != '0) ? rd_cfg_outstd : outstd_t'(1);
    assign in_flight     = issued_q - bursts_returned;
    assign window_open   = in_flight < burst_cnt_t'(limit);
    assign more_to_issue = issued_q != total_bursts;

    // held until accepted, then at least one idle cycle
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            dma_trans_burst_avalid <= 1'b0;
        else if (accept)
            dma_trans_burst_avalid <= 1'b0;
        else if (!dma_trans_burst_avalid && issuing && more_to_issue && window_open)
            dma_trans_burst_avalid <= 1'b1;
    end

    // ==============================
    // address and length
    // ==============================
    always_comb begin
        case (state_q)
            BURST8:  dma_trans_burst_len = burst_len_t'(BURST8_LEN);
            LAST:    dma_trans_burst_len = last_len - 1'b1;
            default: dma_trans_burst_len = '0;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            dma_trans_burst_addr <= '0;
        else if (state_q == LOAD)
            dma_trans_burst_addr <= start_addr;
        else if (accept)   // step by the beats just sent
            dma_trans_burst_addr <= dma_trans_burst_addr
                                  + (addr_t'(dma_trans_burst_len) + 1'b1) * BEAT_BYTES;
    end

endmodule

// ==== hw/rdata_tracker.sv ====
`timescale 1ns/10ps

module rdata_tracker
    import dma_rd_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,

    input  logic       req_pop,
    input  burst_cnt_t total_bursts,
    input  logic       axi_burst_rdata_ok,
    input  logic       read_all_done,

    output burst_cnt_t bursts_returned,
    output logic       data_done,
    output logic       dma_trans_first_burst,
    output logic       dma_trans_last_burst
);

    logic       active_q;
    burst_cnt_t remaining;

    // ==============================
    // returned burst count
    // ==============================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            bursts_returned <= '0;
        else if (req_pop)
            bursts_returned <= '0;
        else if (axi_burst_rdata_ok && !data_done)
            bursts_returned <= bursts_returned + 1'b1;
    end

    // job window, pop to done
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            active_q <= 1'b0;
        else if (req_pop)
            active_q <= 1'b1;
        else if (read_all_done)
            active_q <= 1'b0;
    end

    // ==============================
    // flags
    // ==============================
    assign remaining = total_bursts - bursts_returned;

    assign data_done             = bursts_returned == total_bursts;
    assign dma_trans_first_burst = active_q && (bursts_returned == '0);
    assign dma_trans_last_burst  = active_q && (remaining == burst_cnt_t'(1));  // one to go

endmodule

// ==== hw/rd_addr_manager.sv ====
`timescale 1ns/10ps

module rd_addr_manager
    import dma_rd_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,

    input  logic       rd_cfg_ready,
    input  outstd_t    rd_cfg_outstd,
    input  logic       rd_cfg_outstd_en,

    input  addr_t      raddr_fifo_raddr_in,
    input  word_cnt_t  raddr_fifo_rd_num_word,
    input  logic       raddr_fifo_empty,
    output logic       raddr_fifo_pop,

    input  logic       dma_raddr_burst_ok,
    input  logic       axi_burst_rdata_ok,

    output addr_t      dma_trans_burst_addr,
    output burst_len_t dma_trans_burst_len,
    output logic       dma_trans_burst_avalid,

    output beat_ofs_t  strb_first_beat_num,
    output beat_ofs_t  strb_last_beat_num,
    output logic       dma_trans_first_burst,
    output logic       dma_trans_last_burst,
    output logic       read_all_done
);

    // ==============================
    // internal links
    // ==============================
    addr_t      start_addr;
    burst_cnt_t num_burst8;
    burst_len_t last_len;
    burst_cnt_t total_bursts;
    burst_cnt_t bursts_returned;
    logic       data_done;

    rd_req_decode u_decode (
        .aclk                   (aclk),
        .aresetn                (aresetn),
        .req_pop                (raddr_fifo_pop),
        .raddr_fifo_raddr_in    (raddr_fifo_raddr_in),
        .raddr_fifo_rd_num_word (raddr_fifo_rd_num_word),
        .start_addr             (start_addr),
        .num_burst8             (num_burst8),
        .last_len               (last_len),
        .total_bursts           (total_bursts),
        .strb_first_beat_num    (strb_first_beat_num),
        .strb_last_beat_num     (strb_last_beat_num)
    );

    burst_seq u_seq (
        .aclk                   (aclk),
        .aresetn                (aresetn),
        .rd_cfg_ready           (rd_cfg_ready),
        .rd_cfg_outstd          (rd_cfg_outstd),
        .rd_cfg_outstd_en       (rd_cfg_outstd_en),
        .raddr_fifo_empty       (raddr_fifo_empty),
        .num_burst8             (num_burst8),
        .last_len               (last_len),
        .total_bursts           (total_bursts),
        .start_addr             (start_addr),
        .dma_raddr_burst_ok     (dma_raddr_burst_ok),
        .bursts_returned        (bursts_returned),
        .data_done              (data_done),
        .req_pop                (raddr_fifo_pop),
        .dma_trans_burst_addr   (dma_trans_burst_addr),
        .dma_trans_burst_len    (dma_trans_burst_len),
        .dma_trans_burst_avalid (dma_trans_burst_avalid),
        .read_all_done          (read_all_done)
    );

    rdata_tracker u_tracker (
        .aclk                   (aclk),
        .aresetn                (aresetn),
        .req_pop                (raddr_fifo_pop),
        .total_bursts           (total_bursts),
        .axi_burst_rdata_ok     (axi_burst_rdata_ok),
        .read_all_done          (read_all_done),
        .bursts_returned        (bursts_returned),
        .data_done              (data_done),
        .dma_trans_first_burst  (dma_trans_first_burst),
        .dma_trans_last_burst   (dma_trans_last_burst)
    );

endmodule

// ==== bench/tb_expect.svh ====
`ifndef TB_EXPECT_SVH
`define TB_EXPECT_SVH

// beats touched by a request, rounded up, never below one
function automatic int beat_count(input logic [31:0] addr, input logic [31:0] words);
    logic [31:0] word_addr;
    logic [31:0] first_beat;
    logic [31:0] end_addr;
    int          beats;
    word_addr  = addr & ~32'h3;
    first_beat = word_addr & ~32'hf;
    end_addr   = word_addr + words * 4;
    beats      = (end_addr - first_beat + 15) / 16;
    return (beats == 0) ? 1 : beats;
endfunction

function automatic int burst_count(input int beats);
    return beats / 8 + ((beats % 8) != 0);
endfunction

// full bursts first, the short one last
function automatic logic [3:0] burst_len_at(input int beats, input int idx);
    return (idx < beats / 8) ? 4'd7 : 4'((beats % 8) - 1);
endfunction

function automatic logic [31:0] burst_addr_at(input logic [31:0] addr, input int idx);
    return (addr & ~32'hf) + idx * 128;   // 8 beats of 16 bytes
endfunction

function automatic logic [3:0] first_offset(input logic [31:0] addr);
    return addr[3:0] & 4'hc;
endfunction

function automatic logic [3:0] last_offset(input logic [31:0] addr, input logic [31:0] words);
    return 4'(((addr & ~32'h3) + words * 4) % 16);
endfunction

`endif

// ==== bench/tb_rd_addr_manager.sv ====
`timescale 1ns/10ps

module tb_rd_addr_manager
    import dma_rd_pkg::*;
();

    localparam int NUM_ENTRIES = 5;

    logic       aclk;
    logic       aresetn;
    logic       rd_cfg_ready;
    outstd_t    rd_cfg_outstd;
    logic       rd_cfg_outstd_en;
    addr_t      raddr_fifo_raddr_in;
    word_cnt_t  raddr_fifo_rd_num_word;
    logic       raddr_fifo_empty;
    logic       raddr_fifo_pop;
    logic       dma_raddr_burst_ok;
    logic       axi_burst_rdata_ok;
    addr_t      dma_trans_burst_addr;
    burst_len_t dma_trans_burst_len;
    logic       dma_trans_burst_avalid;
    beat_ofs_t  strb_first_beat_num;
    beat_ofs_t  strb_last_beat_num;
    logic       dma_trans_first_burst;
    logic       dma_trans_last_burst;
    logic       read_all_done;

    `include "tb_expect.svh"

    // one request per entry with address, words, outstd enable and limit, data delay, bursts
    logic [31:0] tab_addr   [NUM_ENTRIES];
    logic [31:0] tab_words  [NUM_ENTRIES];
    logic        tab_en     [NUM_ENTRIES];
    logic [3:0]  tab_outstd [NUM_ENTRIES];
    int          tab_delay  [NUM_ENTRIES];
    int          tab_bursts [NUM_ENTRIES];
    string       tab_name   [NUM_ENTRIES];

    int          errors, tests_run, tests_bad;
    int          cycle_count, cycle_limit;
    logic [31:0] seed;
    logic [31:0] cur_addr, cur_words;
    int          cur_total, cur_limit, cur_delay;
    int          acc_cnt, ret_cnt, peak, pop_cnt, done_cnt, wait_left;
    bit          job_on, holding, after_acc;
    logic [31:0] held_addr;
    logic [3:0]  held_len;
    int          due_q[$];   // cycle at which each data burst returns

    rd_addr_manager dut (
        .aclk                   (aclk),
        .aresetn                (aresetn),
        .rd_cfg_ready           (rd_cfg_ready),
        .rd_cfg_outstd          (rd_cfg_outstd),
        .rd_cfg_outstd_en       (rd_cfg_outstd_en),
        .raddr_fifo_raddr_in    (raddr_fifo_raddr_in),
        .raddr_fifo_rd_num_word (raddr_fifo_rd_num_word),
        .raddr_fifo_empty       (raddr_fifo_empty),
        .raddr_fifo_pop         (raddr_fifo_pop),
        .dma_raddr_burst_ok     (dma_raddr_burst_ok),
        .axi_burst_rdata_ok     (axi_burst_rdata_ok),
        .dma_trans_burst_addr   (dma_trans_burst_addr),
        .dma_trans_burst_len    (dma_trans_burst_len),
        .dma_trans_burst_avalid (dma_trans_burst_avalid),
        .strb_first_beat_num    (strb_first_beat_num),
        .strb_last_beat_num     (strb_last_beat_num),
        .dma_trans_first_burst  (dma_trans_first_burst),
        .dma_trans_last_burst   (dma_trans_last_burst),
        .read_all_done          (read_all_done)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("problem at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic close_test(input string name, input int err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("%s ok", name);
        end else begin
            tests_bad++;
            $display("%s FAIL, %0d errors", name, errors - err_mark);
        end
    endtask

    task automatic check_idle_outputs();
        check_value("dma_trans_burst_avalid", dma_trans_burst_avalid, 0);
        check_value("raddr_fifo_pop", raddr_fifo_pop, 0);
        check_value("read_all_done", read_all_done, 0);
        check_value("dma_trans_burst_addr", dma_trans_burst_addr, 0);
        check_value("dma_trans_burst_len", dma_trans_burst_len, 0);
        check_value("strb_first_beat_num", strb_first_beat_num, 0);
        check_value("strb_last_beat_num", strb_last_beat_num, 0);
    endtask

    task automatic fill_table();
        tab_addr   = '{32'h1000, 32'h2006, 32'h3000, 32'h400c, 32'h5003};
        tab_words  = '{4, 134, 200, 130, 64};
        tab_en     = '{0, 1, 1, 0, 1};
        tab_outstd = '{0, 3, 0, 5, 2};
        tab_delay  = '{3, 20, 25, 30, 2};
        tab_bursts = '{1, 5, 7, 5, 2};
        tab_name   = '{"short aligned request", "long unaligned, limit 3",
                       "limit 0 counts as 1", "limit disabled", "full bursts only"};
    endtask

    // ==============================
    // responder and monitor
    // ==============================
    always @(posedge aclk) begin
        cycle_count++;
        // flags against the state before this edge
        check_value("dma_trans_first_burst", dma_trans_first_burst, job_on && ret_cnt == 0);
        check_value("dma_trans_last_burst", dma_trans_last_burst,
                    job_on && (cur_total - ret_cnt == 1));
        if (raddr_fifo_pop) begin
            pop_cnt++;
            job_on  = 1;
            acc_cnt = 0;
            ret_cnt = 0;
            peak    = 0;
        end
        if (dma_raddr_burst_ok) begin   // accepted at this edge
            check_value("dma_trans_burst_avalid", dma_trans_burst_avalid, 1);
            check_value("dma_trans_burst_addr", dma_trans_burst_addr,
                        burst_addr_at(cur_addr, acc_cnt));
            check_value("dma_trans_burst_len", dma_trans_burst_len,
                        burst_len_at(beat_count(cur_addr, cur_words), acc_cnt));
            if (acc_cnt >= cur_total)
                report_problem("more bursts accepted than the request needs");
            acc_cnt++;
            due_q.push_back(cycle_count + cur_delay);
            dma_raddr_burst_ok <= 1'b0;
            holding   = 0;
            after_acc = 1;
        end else begin
            if (after_acc && dma_trans_burst_avalid)
                report_problem("avalid stayed high in the cycle after an accept");
            after_acc = 0;
            if (dma_trans_burst_avalid) begin
                if (!holding) begin
                    holding   = 1;
                    wait_left = (lcg_next() >> 16) % 4;   // back-pressure cycles
                    held_addr = dma_trans_burst_addr;
                    held_len  = dma_trans_burst_len;
                end else begin
                    check_value("dma_trans_burst_addr", dma_trans_burst_addr, held_addr);
                    check_value("dma_trans_burst_len", dma_trans_burst_len, held_len);
                end
                if (wait_left == 0)
                    dma_raddr_burst_ok <= 1'b1;
                else
                    wait_left--;
            end else if (holding) begin
                report_problem("avalid fell before the burst was accepted");
            end
        end
        if (axi_burst_rdata_ok)
            ret_cnt++;
        if (due_q.size() > 0 && cycle_count >= due_q[0]) begin
            void'(due_q.pop_front());
            axi_burst_rdata_ok <= 1'b1;
        end else begin
            axi_burst_rdata_ok <= 1'b0;
        end
        if (acc_cnt - ret_cnt > cur_limit)
            report_problem("bursts in flight exceed the outstanding limit");
        if (acc_cnt - ret_cnt > peak)
            peak = acc_cnt - ret_cnt;
        if (read_all_done) begin
            done_cnt++;
            check_value("bursts returned at read_all_done", ret_cnt, cur_total);
            check_value("bursts accepted at read_all_done", acc_cnt, cur_total);
            job_on = 0;
        end
    end

    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit)
            @(posedge aclk);
        $display("timeout, the run went past %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

    // ==============================
    // main sequence
    // ==============================
    initial begin
        int err_mark;
        fill_table();
        seed = 32'h3d9565cd;
        {errors, tests_run, tests_bad, cycle_count} = '0;
        {acc_cnt, ret_cnt, peak, pop_cnt, done_cnt, wait_left, cur_total, cur_delay} = '0;
        {job_on, holding, after_acc} = '0;
        cur_limit = 1;
        aresetn = 1'b0;
        rd_cfg_ready = 1'b0;
        rd_cfg_outstd = '0;
        rd_cfg_outstd_en = 1'b0;
        raddr_fifo_raddr_in = '0;
        raddr_fifo_rd_num_word = '0;
        raddr_fifo_empty = 1'b1;
        dma_raddr_burst_ok = 1'b0;
        axi_burst_rdata_ok = 1'b0;
        cycle_limit = 200;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            cycle_limit += burst_count(beat_count(tab_addr[i], tab_words[i]))
                         * (tab_delay[i] + 10);
        end

        err_mark = errors;
        repeat (4) @(posedge aclk);
        aresetn                <= 1'b1;
        raddr_fifo_raddr_in    <= tab_addr[0];   // first request already waiting
        raddr_fifo_rd_num_word <= tab_words[0];
        raddr_fifo_empty       <= 1'b0;
        repeat (4) begin   // idle without rd_cfg_ready
            @(posedge aclk);
            check_idle_outputs();
        end
        close_test("reset", err_mark);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            err_mark = errors;
            @(posedge aclk);
            cur_addr  = tab_addr[i];
            cur_words = tab_words[i];
            cur_total = tab_bursts[i];
            cur_delay = tab_delay[i];
            cur_limit = (tab_en[i] && tab_outstd[i] != 0) ? tab_outstd[i] : 1;
            rd_cfg_outstd          <= tab_outstd[i];
            rd_cfg_outstd_en       <= tab_en[i];
            raddr_fifo_raddr_in    <= tab_addr[i];
            raddr_fifo_rd_num_word <= tab_words[i];
            raddr_fifo_empty       <= 1'b0;
            rd_cfg_ready           <= 1'b1;
            @(posedge aclk);
            rd_cfg_ready <= 1'b0;
            @(posedge aclk);
            while (!raddr_fifo_pop)
                @(posedge aclk);
            raddr_fifo_empty    <= 1'b1;
            raddr_fifo_raddr_in <= ~tab_addr[i];   // fifo moves on to a junk word
            @(posedge aclk);
            check_value("strb_first_beat_num", strb_first_beat_num, first_offset(cur_addr));
            check_value("strb_last_beat_num", strb_last_beat_num,
                        last_offset(cur_addr, cur_words));
            check_value("dma_trans_burst_avalid", dma_trans_burst_avalid, 0);
            @(posedge aclk);
            check_value("dma_trans_burst_avalid", dma_trans_burst_avalid, 0);
            @(posedge aclk);
            check_value("dma_trans_burst_avalid", dma_trans_burst_avalid, 1);
            while (!read_all_done)
                @(posedge aclk);
            repeat (3) @(posedge aclk);
            check_value("accepted bursts", acc_cnt, cur_total);
            check_value("fifo pops so far", pop_cnt, i + 1);
            check_value("read_all_done pulses so far", done_cnt, i + 1);
            if (cur_delay >= 20)   // slow data lets the window fill up
                check_value("peak bursts in flight", peak,
                            (cur_limit < cur_total) ? cur_limit : cur_total);
            close_test(tab_name[i], err_mark);
        end

        $display("summary: %0d tests, %0d failing, %0d errors", tests_run, tests_bad, errors);
        if (tests_bad == 0 && errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+bench
common/dma_rd_pkg.sv
hw/rd_req_decode.sv
hw/burst_seq.sv
hw/rdata_tracker.sv
hw/rd_addr_manager.sv
bench/tb_rd_addr_manager.sv
